// File: source/femtoPkg.sv
// shared widths, reset address, and the state and opcode enums of the
// multi-cycle RV32I core
`default_nettype none

package femtoPkg;

   // data path and register width
   localparam int xlen = 32;
   // internal PC and address adders are narrower than the data path
   localparam int addrWidth = 24;
   localparam int regIndexWidth = 5;

   typedef logic [xlen-1:0] wordT;
   typedef logic [addrWidth-1:0] addrT;
   typedef logic [regIndexWidth-1:0] regIndexT;

   // first instruction fetch after reset
   localparam addrT resetAddr = '0;

   // multi-cycle control states
   typedef enum logic [1:0] {
      fetchInstr,
      waitInstr,
      execute,
      waitMem
   } cpuStateT;

   // major opcode field, instruction bits 6..2
   // values outside this list execute as a no-op
   typedef enum logic [4:0] {
      opLoad   = 5'b00000,
      opAluImm = 5'b00100,
      opAuipc  = 5'b00101,
      opStore  = 5'b01000,
      opAluReg = 5'b01100,
      opLui    = 5'b01101,
      opBranch = 5'b11000,
      opJalr   = 5'b11001,
      opJal    = 5'b11011
   } opcodeT;

endpackage

`default_nettype wire

// File: source/instrDecoder.sv
// instruction register and field decode: opcode class, register indices,
// funct3 and the five immediate formats
`timescale 1ns/1ns
`default_nettype none

module instrDecoder import femtoPkg::*; (
   input  wire logic clk,
   input  wire logic accept,
   input  wire wordT fetchedWord,
   output opcodeT    opcode,
   output regIndexT  rd,
   output regIndexT  rs1Index,
   output regIndexT  rs2Index,
   output logic [2:0] funct3,
   output logic      funct7Alt,
   output wordT      iImm,
   output wordT      sImm,
   output wordT      bImm,
   output wordT      uImm,
   output wordT      jImm
);

   // bits 1..0 are always 11 in RV32I, so they are not kept
   logic [31:2] instr;

   always_ff @(posedge clk) begin
      if (accept) begin
         instr <= fetchedWord[31:2];
      end
   end

   // unknown major opcodes pass through and fall into the default arms
   assign opcode = opcodeT'(instr[6:2]);
   assign rd = instr[11:7];
   assign funct3 = instr[14:12];
   // selects SUB and SRA/SRAI
   assign funct7Alt = instr[30];

   // source indices come from the raw word so the register file
   // can read them in the accept cycle
   assign rs1Index = fetchedWord[19:15];
   assign rs2Index = fetchedWord[24:20];

   // sign-extended immediates
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign uImm = {instr[31:12], 12'b0};
   assign jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

`default_nettype wire

// File: source/registerFile.sv
// 32-entry register file, x0 fixed at zero, two registered read ports
`timescale 1ns/1ns
`default_nettype none

module registerFile import femtoPkg::*; (
   input  wire logic     clk,
   input  wire logic     readEnable,
   input  wire regIndexT rs1Index,
   input  wire regIndexT rs2Index,
   input  wire logic     writeEnable,
   input  wire regIndexT rd,
   input  wire wordT     writeData,
   output wordT          rs1,
   output wordT          rs2
);

   wordT regs [32];

   // all registers start at zero, x0 is never written afterwards
   initial begin
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   end

   always @(posedge clk) begin
      if (writeEnable && rd != '0) begin
         regs[rd] <= writeData;
      end
   end

   // operands captured once per instruction
   always_ff @(posedge clk) begin
      if (readEnable) begin
         rs1 <= regs[rs1Index];
         rs2 <= regs[rs2Index];
      end
   end

endmodule

`default_nettype wire

// File: source/aluUnit.sv
// ALU with adder, shared subtract-compare, bit-reversing shifter and the
// branch predicate
`timescale 1ns/1ns
`default_nettype none

module aluUnit import femtoPkg::*; (
   input  wire opcodeT     opcode,
   input  wire logic [2:0] funct3,
   input  wire logic       funct7Alt,
   input  wire wordT       rs1,
   input  wire wordT       rs2,
   input  wire wordT       iImm,
   output wordT            aluResult,
   output wordT            aluSum,
   output logic            takeBranch
);

   wordT aluIn2;
   logic [xlen:0] aluMinus;
   logic lessThan;
   logic lessThanU;
   logic equal;
   wordT rs1Rev;
   wordT shiftIn;
   logic shiftFill;
   logic signed [xlen:0] shifted;
   wordT shiftLeft;

   // register ops and branches compare rs2, everything else uses the I-immediate
   assign aluIn2 = (opcode == opAluReg || opcode == opBranch) ? rs2 : iImm;

   // also the JALR target
   assign aluSum = rs1 + aluIn2;

   // one 33-bit subtract: bit 32 is the borrow, i.e. unsigned less-than
   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   assign lessThanU = aluMinus[xlen];
   // differing signs decide the signed compare directly
   assign lessThan = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : aluMinus[xlen];
   assign equal = (aluMinus[xlen-1:0] == '0);

   // left shifts run through the right shifter on bit-reversed data
   assign rs1Rev = {<<{rs1}};
   assign shiftIn = (funct3 == 3'b001) ? rs1Rev : rs1;
   // sign fill only for SRA/SRAI
   assign shiftFill = funct7Alt & (funct3 == 3'b101) & rs1[xlen-1];
   assign shifted = $signed({shiftFill, shiftIn}) >>> aluIn2[4:0];
   assign shiftLeft = {<<{shifted[xlen-1:0]}};

   always_comb begin
      case (funct3)
         // SUB exists only as a register op, ADDI reuses bit 30 as immediate
         3'b000: aluResult = (opcode == opAluReg && funct7Alt) ? aluMinus[xlen-1:0] : aluSum;
         3'b001: aluResult = shiftLeft;
         3'b010: aluResult = {{(xlen-1){1'b0}}, lessThan};
         3'b011: aluResult = {{(xlen-1){1'b0}}, lessThanU};
         3'b100: aluResult = rs1 ^ aluIn2;
         3'b101: aluResult = shifted[xlen-1:0];
         3'b110: aluResult = rs1 | aluIn2;
         default: aluResult = rs1 & aluIn2;
      endcase
   end

   // BEQ BNE BLT BGE BLTU BGEU, funct3 010 and 011 never branch
   always_comb begin
      case (funct3)
         3'b000: takeBranch = equal;
         3'b001: takeBranch = !equal;
         3'b100: takeBranch = lessThan;
         3'b101: takeBranch = !lessThan;
         3'b110: takeBranch = lessThanU;
         3'b111: takeBranch = !lessThanU;
         default: takeBranch = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// File: source/loadStoreAlign.sv
// byte and halfword alignment for loads and stores, store byte mask
`timescale 1ns/1ns
`default_nettype none

module loadStoreAlign import femtoPkg::*; (
   input  wire logic [2:0] funct3,
   input  wire logic [1:0] byteOffset,
   input  wire wordT       rs2,
   input  wire wordT       memRdata,
   output wordT            loadValue,
   output wordT            storeData,
   output logic [3:0]      storeMask
);

   logic byteAccess;
   logic halfAccess;
   logic [15:0] loadHalf;
   logic [7:0] loadByte;
   logic loadSign;

   // funct3[1:0]: 00 byte, 01 halfword, 10 word
   assign byteAccess = (funct3[1:0] == 2'b00);
   assign halfAccess = (funct3[1:0] == 2'b01);

   // pick the halfword first, then the byte within it
   assign loadHalf = byteOffset[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = byteOffset[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means LBU/LHU
   assign loadSign = !funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadValue = byteAccess ? {{24{loadSign}}, loadByte} :
                      halfAccess ? {{16{loadSign}}, loadHalf} :
                      memRdata;

   // store data is replicated so the addressed lane always holds it
   assign storeData[7:0] = rs2[7:0];
   assign storeData[15:8] = byteOffset[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = byteOffset[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = byteOffset[0] ? rs2[7:0] :
                             byteOffset[1] ? rs2[15:8] : rs2[31:24];

   // one-hot byte, paired halfword, or full word
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << byteOffset;
      end else if (halfAccess) begin
         storeMask = byteOffset[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

endmodule

`default_nettype wire

// File: source/coreControl.sv
// control FSM, program counter, next-PC and write-back selection,
// memory strobes and address mux
`timescale 1ns/1ns
`default_nettype none

module coreControl import femtoPkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   input  wire opcodeT     opcode,
   input  wire wordT       uImm,
   input  wire wordT       bImm,
   input  wire wordT       jImm,
   input  wire wordT       iImm,
   input  wire wordT       sImm,
   input  wire wordT       rs1,
   input  wire wordT       aluResult,
   input  wire wordT       aluSum,
   input  wire logic       takeBranch,
   input  wire wordT       loadValue,
   input  wire logic [3:0] storeMask,
   input  wire logic       memRbusy,
   input  wire logic       memWbusy,
   output logic            accept,
   output logic            regWrite,
   output wordT            writeData,
   output logic [1:0]      byteOffset,
   output wordT            memAddr,
   output logic [3:0]      memWmask,
   output logic            memRstrb
);

   cpuStateT state;
   addrT pc;
   addrT pcPlus4;
   addrT pcPlusImm;
   addrT lsAddr;
   addrT nextPc;
   logic isMem;
   logic execWrite;
   // a load is outstanding in waitMem
   logic loadPending;
   logic memIdle;

   assign pcPlus4 = pc + addrWidth'(4);
   // one adder shared by JAL, AUIPC and branches
   assign pcPlusImm = pc + ((opcode == opJal)   ? jImm[addrWidth-1:0] :
                            (opcode == opAuipc) ? uImm[addrWidth-1:0] :
                                                  bImm[addrWidth-1:0]);
   // separate adder for the load/store address
   assign lsAddr = rs1[addrWidth-1:0] +
                   ((opcode == opStore) ? sImm[addrWidth-1:0] : iImm[addrWidth-1:0]);
   assign byteOffset = lsAddr[1:0];

   // JALR clears bit 0 of its target
   assign nextPc = (opcode == opJalr) ? {aluSum[addrWidth-1:1], 1'b0} :
                   (opcode == opJal || (opcode == opBranch && takeBranch)) ? pcPlusImm :
                   pcPlus4;

   assign isMem = (opcode == opLoad) || (opcode == opStore);
   assign memIdle = !memRbusy && !memWbusy;

   // write-back value by opcode, upper address bits read as zero
   always_comb begin
      case (opcode)
         opLui: writeData = uImm;
         opAuipc: writeData = {{(xlen-addrWidth){1'b0}}, pcPlusImm};
         opJal, opJalr: writeData = {{(xlen-addrWidth){1'b0}}, pcPlus4};
         opLoad: writeData = loadValue;
         default: writeData = aluResult;
      endcase
   end

   // results written in execute, illegal opcodes write nothing
   always_comb begin
      case (opcode)
         opLui, opAuipc, opJal, opJalr, opAluImm, opAluReg: execWrite = 1'b1;
         default: execWrite = 1'b0;
      endcase
   end

   assign regWrite = (state == execute && execWrite) ||
                     (state == waitMem && loadPending && memIdle);

   assign accept = (state == waitInstr) && !memRbusy;
   assign memRstrb = (state == fetchInstr) || (state == execute && opcode == opLoad);
   assign memWmask = (state == execute && opcode == opStore) ? storeMask : 4'b0000;
   assign memAddr = (state == fetchInstr || state == waitInstr) ?
                    {{(xlen-addrWidth){1'b0}}, pc} :
                    {{(xlen-addrWidth){1'b0}}, lsAddr};

   always_ff @(posedge clk) begin
      if (!reset) begin
         // wait for both busy lines before the first fetch
         state <= waitMem;
         pc <= resetAddr;
         loadPending <= 1'b0;
      end else begin
         case (state)
            fetchInstr: begin
               state <= waitInstr;
            end
            waitInstr: begin
               if (!memRbusy) begin
                  state <= execute;
               end
            end
            execute: begin
               pc <= nextPc;
               loadPending <= (opcode == opLoad);
               state <= isMem ? waitMem : fetchInstr;
            end
            default: begin
               if (memIdle) begin
                  loadPending <= 1'b0;
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: source/femtoCore.sv
// top level of the RV32I core, connects decoder, register file, ALU,
// load/store alignment and control
`timescale 1ns/1ns
`default_nettype none

module femtoCore import femtoPkg::*; (
   input  wire logic       clk,
   input  wire logic       reset,
   output wordT            memAddr,
   output wordT            memWdata,
   output logic [3:0]      memWmask,
   input  wire wordT       memRdata,
   output logic            memRstrb,
   input  wire logic       memRbusy,
   input  wire logic       memWbusy
);

   opcodeT opcode;
   regIndexT rd;
   regIndexT rs1Index;
   regIndexT rs2Index;
   logic [2:0] funct3;
   logic funct7Alt;
   wordT iImm;
   wordT sImm;
   wordT bImm;
   wordT uImm;
   wordT jImm;
   wordT rs1;
   wordT rs2;
   wordT aluResult;
   wordT aluSum;
   logic takeBranch;
   wordT loadValue;
   logic [3:0] storeMask;
   logic accept;
   logic regWrite;
   wordT writeData;
   logic [1:0] byteOffset;

   // instruction word comes straight off the read data bus
   instrDecoder decoder (
      .clk, .accept, .fetchedWord(memRdata), .opcode, .rd, .rs1Index, .rs2Index,
      .funct3, .funct7Alt, .iImm, .sImm, .bImm, .uImm, .jImm
   );

   // operands are read in the same cycle the instruction is accepted
   registerFile regFile (
      .clk, .readEnable(accept), .rs1Index, .rs2Index,
      .writeEnable(regWrite), .rd, .writeData, .rs1, .rs2
   );

   aluUnit alu (
      .opcode, .funct3, .funct7Alt, .rs1, .rs2, .iImm,
      .aluResult, .aluSum, .takeBranch
   );

   // store data leaves the core already lane-replicated
   loadStoreAlign lsAlign (
      .funct3, .byteOffset, .rs2, .memRdata,
      .loadValue, .storeData(memWdata), .storeMask
   );

   coreControl control (
      .clk, .reset, .opcode, .uImm, .bImm, .jImm, .iImm, .sImm, .rs1,
      .aluResult, .aluSum, .takeBranch, .loadValue, .storeMask, .memRbusy, .memWbusy,
      .accept, .regWrite, .writeData, .byteOffset, .memAddr, .memWmask, .memRstrb
   );

endmodule

`default_nettype wire

// File: include/isaModel.svh
// architectural RV32I model: ALU rule and a one-instruction step over
// the testbench copies of registers, PC and data memory
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// integer ops by funct3, alt picks SUB or SRA
function automatic wordT aluModel(input logic [2:0] f3, input logic alt,
                                  input wordT x, input wordT y);
   wordT r;
   case (f3)
      3'b000: r = alt ? x - y : x + y;
      3'b001: r = x << y[4:0];
      3'b010: r = wordT'($signed(x) < $signed(y));
      3'b011: r = wordT'(x < y);
      3'b100: r = x ^ y;
      3'b101: begin
         if (alt) begin
            r = $signed(x) >>> y[4:0];
         end else begin
            r = x >> y[4:0];
         end
      end
      3'b110: r = x | y;
      default: r = x & y;
   endcase
   return r;
endfunction

// executes one instruction, reports the memory access it should cause
function automatic void stepModel(input wordT instr, output logic isLoad,
      output wordT loadAddr, output logic isStore, output wordT storeAddr,
      output wordT storeData, output logic [3:0] storeMask);
   wordT a;
   wordT b;
   wordT iImm;
   wordT bImm;
   wordT result;
   wordT laneWord;
   addrT addr;
   addrT nextPc;
   logic [2:0] f3;
   logic writeRd;
   logic taken;
   a = modelRegs[instr[19:15]];
   b = modelRegs[instr[24:20]];
   f3 = instr[14:12];
   iImm = {{20{instr[31]}}, instr[31:20]};
   bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   isLoad = 1'b0;
   isStore = 1'b0;
   loadAddr = '0;
   storeAddr = '0;
   storeData = '0;
   storeMask = 4'b0000;
   writeRd = 1'b1;
   result = '0;
   nextPc = modelPc + addrT'(4);
   case (instr[6:2])
      opLui: result = {instr[31:12], 12'b0};
      // address arithmetic is addrWidth bits wide, upper bits read as zero
      opAuipc: result = wordT'(modelPc + addrT'({instr[31:12], 12'b0}));
      opJal: begin
         result = wordT'(modelPc + addrT'(4));
         nextPc = modelPc + addrT'({{12{instr[31]}}, instr[19:12], instr[20],
                                    instr[30:21], 1'b0});
      end
      opJalr: begin
         result = wordT'(modelPc + addrT'(4));
         nextPc = addrT'(a + iImm) & ~addrT'(1);
      end
      // only shift-right immediates carry the alt bit
      opAluImm: result = aluModel(f3, (f3 == 3'b101) && instr[30], a, iImm);
      opAluReg: result = aluModel(f3, instr[30], a, b);
      opBranch: begin
         writeRd = 1'b0;
         case (f3)
            3'b000: taken = (a == b);
            3'b001: taken = (a != b);
            3'b100: taken = $signed(a) < $signed(b);
            3'b101: taken = $signed(a) >= $signed(b);
            3'b110: taken = a < b;
            3'b111: taken = a >= b;
            default: taken = 1'b0;
         endcase
         if (taken) begin
            nextPc = modelPc + addrT'(bImm);
         end
      end
      opLoad: begin
         addr = addrT'(a + iImm);
         isLoad = 1'b1;
         loadAddr = wordT'(addr);
         // addressed byte moved down to lane 0
         laneWord = modelMem[addr[10:2]] >> (8 * addr[1:0]);
         case (f3)
            3'b000: result = {{24{laneWord[7]}}, laneWord[7:0]};
            3'b001: result = {{16{laneWord[15]}}, laneWord[15:0]};
            3'b100: result = {24'b0, laneWord[7:0]};
            3'b101: result = {16'b0, laneWord[15:0]};
            default: result = laneWord;
         endcase
      end
      opStore: begin
         writeRd = 1'b0;
         addr = addrT'(a + {{20{instr[31]}}, instr[31:25], instr[11:7]});
         isStore = 1'b1;
         storeAddr = wordT'(addr);
         storeMask = (f3 == 3'b000) ? 4'b0001 << addr[1:0] :
                     (f3 == 3'b001) ? 4'b0011 << addr[1:0] : 4'b1111;
         storeData = b << (8 * addr[1:0]);
         for (int i = 0; i < 4; i++) begin
            if (storeMask[i]) begin
               modelMem[addr[10:2]][8*i +: 8] = storeData[8*i +: 8];
            end
         end
      end
      default: writeRd = 1'b0;
   endcase
   if (writeRd && instr[11:7] != 5'd0) begin
      modelRegs[instr[11:7]] = result;
   end
   modelPc = nextPc;
endfunction

`endif

// File: verif/coreTb.sv
// testbench for the RV32I core: random program, memory model with random
// busy, architectural reference and compare process
`timescale 1ns/1ns
`default_nettype none

module coreTb import femtoPkg::*; ();

   // 200 words of code from address 0, data region well above it
   localparam int programSize = 200;
   localparam int memWords = 512;
   localparam int dataBase = 'h400;
   localparam int maxBusy = 2;
   localparam int timeoutCycles = programSize * 12 + 20;
   localparam addrT loopAddr = addrT'((programSize - 1) * 4);

   logic clk = 1'b0;
   logic reset;
   wordT memAddr;
   wordT memWdata;
   logic [3:0] memWmask;
   wordT memRdata = '0;
   logic memRstrb;
   // busy held high through reset
   logic memRbusy = 1'b1;
   logic memWbusy = 1'b1;

   // memory seen by the DUT
   wordT mem [memWords];
   // architectural copy stepped by the reference
   wordT modelRegs [32];
   addrT modelPc;
   wordT modelMem [memWords];

   logic memReady;
   wordT pendingData;
   int readBusyLeft;
   int writeBusyLeft;
   int progLen;
   int cycleCount;
   int loopFetches;
   int dutWrites;
   int modelWrites;
   // next expected memory event after a fetch
   logic expectLoad = 1'b0;
   logic expectStore = 1'b0;
   wordT expLoadAddr;
   wordT expStoreAddr;
   wordT expStoreData;
   logic [3:0] expStoreMask;

   `include "isaModel.svh"

   femtoCore UUT (
      .clk, .reset, .memAddr, .memWdata, .memWmask, .memRdata,
      .memRstrb, .memRbusy, .memWbusy
   );

   always #50 clk = ~clk;

   task automatic failRun(input string reason);
      $display("%s", reason);
      $display("ERRORS FOUND");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input wordT actual, input wordT expected);
      if (actual !== expected) begin
         failRun($sformatf("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected));
      end
   endtask

   task automatic checkMask(input string name, input logic [3:0] actual,
                            input logic [3:0] expected);
      if (actual !== expected) begin
         failRun($sformatf("Mismatch %s: actual 0x%h expected 0x%h", name, actual, expected));
      end
   endtask

   // byte mask widened to bit lanes
   function automatic wordT laneBits(input logic [3:0] m);
      return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
   endfunction

   // instruction formats
   function automatic wordT encR(input logic [6:0] f7, input regIndexT rs2,
         input regIndexT rs1, input logic [2:0] f3, input regIndexT rd, input logic [4:0] op);
      return {f7, rs2, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic wordT encI(input logic [11:0] imm, input regIndexT rs1,
         input logic [2:0] f3, input regIndexT rd, input logic [4:0] op);
      return {imm, rs1, f3, rd, op, 2'b11};
   endfunction

   function automatic wordT encS(input logic [11:0] imm, input regIndexT rs2,
         input regIndexT rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 5'(opStore), 2'b11};
   endfunction

   function automatic wordT encB(input logic [12:0] imm, input regIndexT rs2,
         input regIndexT rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 5'(opBranch), 2'b11};
   endfunction

   function automatic wordT encU(input logic [19:0] imm, input regIndexT rd,
         input logic [4:0] op);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic wordT encJ(input logic [20:0] imm, input regIndexT rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 5'(opJal), 2'b11};
   endfunction

   function automatic regIndexT randomReg();
      return regIndexT'($urandom_range(31, 0));
   endfunction

   // register or immediate ALU op, alt bit only where the ISA defines it
   function automatic wordT randomAluOp(input regIndexT rd);
      logic [2:0] f3;
      logic alt;
      f3 = 3'($urandom_range(7, 0));
      alt = 1'($urandom_range(1, 0));
      if ($urandom_range(1, 0) == 1) begin
         return encR((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                     randomReg(), randomReg(), f3, rd, opAluReg);
      end
      if (f3 == 3'b001 || f3 == 3'b101) begin
         return encI({1'b0, alt && (f3 == 3'b101), 5'b0, 5'($urandom_range(31, 0))},
                     randomReg(), f3, rd, opAluImm);
      end
      return encI(12'($urandom), randomReg(), f3, rd, opAluImm);
   endfunction

   task automatic emit(input wordT word);
      mem[progLen] = word;
      progLen++;
   endtask

   // random program of instruction groups, ends in a jump to itself
   task automatic buildProgram();
      int kind;
      int skip;
      int slot;
      int off;
      int n;
      regIndexT rd;
      logic [2:0] f3;
      progLen = 0;
      slot = 0;
      while (progLen < programSize - 8) begin
         kind = int'($urandom_range(9, 0));
         rd = regIndexT'($urandom_range(31, 1));
         case (kind)
            0: emit(encU(20'($urandom), rd, opLui));
            1: emit(encU(20'($urandom), rd, opAuipc));
            2: emit(encI(12'($urandom), randomReg(), 3'b000, rd, opAluImm));
            3, 4, 5: emit(randomAluOp(rd));
            6: begin
               // forward branch over 1 to 3 instructions
               skip = int'($urandom_range(3, 1));
               n = int'($urandom_range(5, 0));
               f3 = (n < 2) ? 3'(n) : 3'(n + 2);
               emit(encB(13'((skip + 1) * 4), randomReg(), randomReg(), f3));
               repeat (skip) emit(randomAluOp(regIndexT'($urandom_range(31, 1))));
            end
            7: begin
               emit(encJ(21'd8, rd));
               emit(randomAluOp(regIndexT'($urandom_range(31, 1))));
            end
            8: begin
               // absolute target through x0
               emit(encI(12'(progLen * 4 + 8), 5'd0, 3'b000, rd, opJalr));
               emit(randomAluOp(regIndexT'($urandom_range(31, 1))));
            end
            default: begin
               n = int'($urandom_range(4, 0));
               f3 = (n < 3) ? 3'(n) : 3'(n + 1);
               off = int'($urandom_range(255, 0)) & ~((1 << f3[1:0]) - 1);
               emit(encI(12'(dataBase + off), 5'd0, f3, rd, opLoad));
               f3 = 3'($urandom_range(2, 0));
               off = int'($urandom_range(255, 0)) & ~((1 << f3[1:0]) - 1);
               emit(encS(12'(dataBase + off), randomReg(), 5'd0, f3));
            end
         endcase
         // every destination gets stored so its value shows on the bus
         if (kind != 6) begin
            emit(encS(12'(dataBase + 4 * (slot % 32)), rd, 5'd0, 3'b010));
            slot++;
         end
      end
      while (progLen < programSize - 1) begin
         emit(randomAluOp(regIndexT'($urandom_range(31, 1))));
      end
      emit(encJ(21'd0, 5'd0));
   endtask

   initial begin
      void'($urandom(57));
      reset <= 1'b0;
      memReady <= 1'b0;
      // fill value differs for every word address
      for (int i = 0; i < memWords; i++) begin
         mem[i] = wordT'(i) * 32'h9E37_79B1 + 32'h0123_4567;
      end
      buildProgram();
      for (int i = 0; i < memWords; i++) begin
         modelMem[i] = mem[i];
      end
      for (int i = 0; i < 32; i++) begin
         modelRegs[i] = '0;
      end
      modelPc = resetAddr;
      repeat (4) @(negedge clk);
      reset <= 1'b1;
      repeat (2) @(negedge clk);
      memReady <= 1'b1;
      // two fetches of the final loop close the run
      wait (loopFetches >= 2);
      @(negedge clk);
      if (dutWrites != modelWrites) begin
         failRun($sformatf("Mismatch writeCount: actual 0x%h expected 0x%h",
                           dutWrites, modelWrites));
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

   // outputs are sampled here before the next inputs are driven
   always @(negedge clk) begin
      cycleCount++;
      if (cycleCount > timeoutCycles) begin
         failRun($sformatf("timeout: core did not reach the final loop in %0d cycles",
                           timeoutCycles));
      end
      if (memRstrb) begin
         if (memRbusy || memWbusy) begin
            failRun("read strobe raised while the memory is busy");
         end
         if (expectStore) begin
            failRun("read strobe seen where a store was expected");
         end
         if (expectLoad) begin
            checkWord("memAddr", memAddr, expLoadAddr);
            expectLoad = 1'b0;
         end else begin
            // instruction fetch, step the model one instruction
            checkWord("memAddr", memAddr, wordT'(modelPc));
            if (modelPc == loopAddr) begin
               loopFetches++;
            end
            stepModel(modelMem[modelPc[10:2]], expectLoad, expLoadAddr, expectStore,
                      expStoreAddr, expStoreData, expStoreMask);
            if (expectStore) begin
               modelWrites++;
            end
         end
         pendingData = mem[memAddr[10:2]];
         readBusyLeft = int'($urandom_range(maxBusy, 0));
      end
      if (memWmask != 4'b0000) begin
         if (memRbusy || memWbusy) begin
            failRun("write raised while the memory is busy");
         end
         if (!expectStore) begin
            failRun("write seen where no store was expected");
         end
         checkWord("memAddr", memAddr, expStoreAddr);
         checkMask("memWmask", memWmask, expStoreMask);
         // only the enabled lanes carry store data
         checkWord("memWdata", memWdata & laneBits(memWmask),
                   expStoreData & laneBits(expStoreMask));
         for (int i = 0; i < 4; i++) begin
            if (memWmask[i]) begin
               mem[memAddr[10:2]][8*i +: 8] = memWdata[8*i +: 8];
            end
         end
         expectStore = 1'b0;
         dutWrites++;
         writeBusyLeft = int'($urandom_range(maxBusy, 0));
      end
      if (!memReady) begin
         memRbusy <= 1'b1;
         memWbusy <= 1'b1;
      end else begin
         memRbusy <= (readBusyLeft != 0);
         // inverted data while busy, so an early consume shows up
         memRdata <= (readBusyLeft != 0) ? ~pendingData : pendingData;
         memWbusy <= (writeBusyLeft != 0);
         if (readBusyLeft != 0) begin
            readBusyLeft--;
         end
         if (writeBusyLeft != 0) begin
            writeBusyLeft--;
         end
      end
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
source/femtoPkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/loadStoreAlign.sv
source/coreControl.sv
source/femtoCore.sv
verif/coreTb.sv

// File: run.sh
#!/bin/sh
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module coreTb -o coreSim > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/coreSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   exit 1
fi
if [ $simStatus -ne 0 ]; then
   echo "simulation exited with status $simStatus"
   exit 1
fi
exit 0
